//--- list.f
+incdir+include
design/oc_pkg.sv
design/oc_if.sv
design/operand_collector.sv
design/oc_arbiter.sv
design/oc_ex_mux.sv
design/oc_stage_top.sv
verif/oc_sva.sv
verif/oc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= oc_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_STR  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the pass line in the log decides the result
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/oc_tb.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module oc_tb;

    localparam int NUM_INSTR = 200;
    localparam int CLK_NS    = 100;

    logic                   clk;
    logic                   rst;
    logic                   issue_valid;
    logic [`OC_IDX_W-1:0]   issue_oc;
    logic [`OC_WARP_W-1:0]  issue_warp;
    logic [`OC_INSTR_W-1:0] issue_instr;
    logic [`OC_SCB_W-1:0]   issue_scb;
    logic [`OC_LANES-1:0]   issue_mask;
    logic                   rd_valid;
    logic [`OC_IDX_W-1:0]   rd_oc;
    logic                   rd_slot;
    logic [`OC_DATA_W-1:0]  rd_data;
    logic                   ex_ready;
    logic [`OC_NUM-1:0]     oc_free;
    logic                   ex_valid;
    logic [`OC_WARP_W-1:0]  ex_warp;
    logic [`OC_INSTR_W-1:0] ex_instr;
    logic                   ex_reg_write;
    logic [`OC_IMM_W-1:0]   ex_imm;
    logic                   ex_imm_valid;
    logic [`OC_ALUOP_W-1:0] ex_alu_op;
    logic                   ex_mem_write;
    logic                   ex_mem_read;
    logic                   ex_shared_gbar;
    logic                   ex_beq;
    logic                   ex_blt;
    logic [`OC_SCB_W-1:0]   ex_scb;
    logic [`OC_LANES-1:0]   ex_mask;
    logic [`OC_REG_W-1:0]   ex_dst;
    logic [`OC_DATA_W-1:0]  ex_src0;
    logic [`OC_DATA_W-1:0]  ex_src1;
    oc_pkg::oc_entry_t      got_entry;

    // model state
    integer                 seed;
    int                     issued;
    int                     received;
    int                     m_last;
    logic [`OC_NUM-1:0]     m_busy;
    logic [1:0]             m_need [`OC_NUM];
    logic [1:0]             m_filled [`OC_NUM];
    oc_pkg::oc_entry_t      m_entry [`OC_NUM];
    oc_pkg::operand_t       m_src0 [`OC_NUM];
    oc_pkg::operand_t       m_src1 [`OC_NUM];
    logic                   m_valid;
    oc_pkg::oc_entry_t      m_out;
    oc_pkg::operand_t       m_out0;
    oc_pkg::operand_t       m_out1;

    oc_stage_top dut (.*);

    assign got_entry = {ex_warp, ex_instr, ex_reg_write, ex_imm, ex_imm_valid, ex_alu_op,
                        ex_mem_write, ex_mem_read, ex_shared_gbar, ex_beq, ex_blt,
                        ex_scb, ex_mask, ex_dst};

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_entry(input oc_pkg::oc_entry_t got, input oc_pkg::oc_entry_t exp);
        if (got !== exp)
        begin
            $display("FAIL ex_entry: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_operand(input string name, input oc_pkg::operand_t got,
                                 input oc_pkg::operand_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_free(input logic [`OC_NUM-1:0] got, input logic [`OC_NUM-1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL oc_free: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL ex_valid: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    // alu op in 31:28, fmt 27, dst 26:22, flags 21:16, low half 15:0
    function automatic oc_pkg::oc_entry_t decode_word(input logic [`OC_WARP_W-1:0] warp,
        input logic [31:0] w, input logic [`OC_SCB_W-1:0] scb, input logic [`OC_LANES-1:0] mask);
        oc_pkg::oc_entry_t e;
        e             = '0;
        e.warp        = warp;
        e.instr       = w;
        e.scb         = scb;
        e.mask        = mask;
        e.alu_op      = w[31:28];
        e.dst         = w[26:22];
        e.reg_write   = w[21];
        e.mem_read    = w[20];
        e.mem_write   = w[19];
        e.shared_gbar = w[18];
        e.beq         = w[17];
        e.blt         = w[16];
        if (w[27])
        begin
            e.imm       = w[15:0];
            e.imm_valid = 1'b1;
        end
        return e;
    endfunction

    function automatic oc_pkg::operand_t random_operand();
        oc_pkg::operand_t d;
        for (int i = 0; i < `OC_DATA_W / 32; i++)
            d[i*32 +: 32] = $random(seed);
        return d;
    endfunction

    task automatic drive_inputs();
        int          pick;
        logic [31:0] r;
        int          cand_oc [$];
        int          cand_slot [$];
        issue_valid = 1'b0;
        rd_valid    = 1'b0;
        if (issued < NUM_INSTR && m_busy != '1 && ($random(seed) & 3) != 0)
        begin
            pick = $random(seed) & 3;
            while (m_busy[pick])   // walk to a free one
                pick = (pick + 1) & 3;
            r           = $random(seed);
            issue_valid = 1'b1;
            issue_oc    = pick[1:0];
            issue_warp  = r[2:0];
            issue_scb   = r[4:3];
            issue_mask  = r[12:5];
            issue_instr = $random(seed);
            issued++;
        end
        for (int c = 0; c < `OC_NUM; c++)
            for (int s = 0; s < 2; s++)
                if (m_busy[c] && m_need[c][s] && !m_filled[c][s])
                begin
                    cand_oc.push_back(c);
                    cand_slot.push_back(s);
                end
        if (cand_oc.size() > 0 && ($random(seed) & 3) != 0)
        begin
            pick     = $unsigned($random(seed)) % cand_oc.size();
            rd_valid = 1'b1;
            rd_oc    = cand_oc[pick][1:0];
            rd_slot  = (cand_slot[pick] == 1);
            rd_data  = random_operand();
        end
        ex_ready = ($random(seed) & 1) != 0;
    endtask

    // next state as the DUT takes it at the coming rising edge
    task automatic model_step();
        logic adv;
        logic found;
        int   g;
        int   idx;
        adv   = !m_valid || ex_ready;
        found = 1'b0;
        g     = 0;
        if (adv)
        begin
            for (int k = 1; k <= `OC_NUM; k++)
            begin
                idx = (m_last + k) % `OC_NUM;
                if (!found && m_busy[idx] && ((m_filled[idx] & m_need[idx]) == m_need[idx]))
                begin
                    found = 1'b1;
                    g     = idx;
                end
            end
            m_valid = found;
        end
        if (found)
        begin
            m_out     = m_entry[g];
            m_out0    = m_src0[g];
            m_out1    = m_need[g][1] ? m_src1[g] : '0;
            m_last    = g;
            m_busy[g] = 1'b0;
            received++;
        end
        if (issue_valid)
        begin
            m_busy[issue_oc]   = 1'b1;
            m_filled[issue_oc] = 2'b00;
            m_need[issue_oc]   = issue_instr[27] ? 2'b01 : 2'b11;
            m_entry[issue_oc]  = decode_word(issue_warp, issue_instr, issue_scb, issue_mask);
        end
        if (rd_valid)
        begin
            m_filled[rd_oc][rd_slot] = 1'b1;
            if (rd_slot)
                m_src1[rd_oc] = rd_data;
            else
                m_src0[rd_oc] = rd_data;
        end
    endtask

    task automatic compare_outputs();
        check_free(oc_free, ~m_busy);
        check_valid(ex_valid, m_valid);
        if (m_valid)
        begin
            check_entry(got_entry, m_out);
            check_operand("ex_src0", ex_src0, m_out0);
            check_operand("ex_src1", ex_src1, m_out1);
        end
    endtask

    initial
    begin
        seed        = 69115;
        issued      = 0;
        received    = 0;
        m_last      = `OC_NUM - 1;   // first search starts at collector 0
        m_busy      = '0;
        m_valid     = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_oc    = '0;
        issue_warp  = '0;
        issue_instr = '0;
        issue_scb   = '0;
        issue_mask  = '0;
        rd_valid    = 1'b0;
        rd_oc       = '0;
        rd_slot     = 1'b0;
        rd_data     = '0;
        ex_ready    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (received < NUM_INSTR)
        begin
            compare_outputs();
            drive_inputs();
            model_step();
            @(negedge clk);
        end
        compare_outputs();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial
    begin
        #(NUM_INSTR * 20 * CLK_NS);
        $display("ERROR: timeout, outputs stopped arriving (%0d of %0d received)",
                 received, NUM_INSTR);
        stop_on_error();
    end

endmodule

//--- verif/oc_sva.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module oc_sva
(
    input logic                   clk,
    input logic                   rst,
    input logic                   issue_valid,
    input logic [`OC_IDX_W-1:0]   issue_oc,
    input logic [`OC_NUM-1:0]     oc_free,
    input logic [`OC_NUM-1:0]     grt,
    input logic                   ex_ready,
    input logic                   ex_valid,
    input logic [`OC_WARP_W-1:0]  ex_warp,
    input logic [`OC_INSTR_W-1:0] ex_instr,
    input logic                   ex_reg_write,
    input logic [`OC_IMM_W-1:0]   ex_imm,
    input logic                   ex_imm_valid,
    input logic [`OC_ALUOP_W-1:0] ex_alu_op,
    input logic                   ex_mem_write,
    input logic                   ex_mem_read,
    input logic                   ex_shared_gbar,
    input logic                   ex_beq,
    input logic                   ex_blt,
    input logic [`OC_SCB_W-1:0]   ex_scb,
    input logic [`OC_LANES-1:0]   ex_mask,
    input logic [`OC_REG_W-1:0]   ex_dst,
    input logic [`OC_DATA_W-1:0]  ex_src0,
    input logic [`OC_DATA_W-1:0]  ex_src1
);

    oc_pkg::oc_entry_t held_entry;

    assign held_entry = {ex_warp, ex_instr, ex_reg_write, ex_imm, ex_imm_valid, ex_alu_op,
                         ex_mem_write, ex_mem_read, ex_shared_gbar, ex_beq, ex_blt,
                         ex_scb, ex_mask, ex_dst};

    a_reset_clear: assert property (@(posedge clk) rst |=> !ex_valid)
        else $error("ex_valid high after reset");

    // stalled output keeps every field
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && !ex_ready) |=> (ex_valid && $stable(held_entry)
            && $stable(ex_src0) && $stable(ex_src1)))
        else $error("output changed during stall");

    a_issue_free: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> oc_free[issue_oc])
        else $error("issue into busy collector %0d", issue_oc);

    a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(grt))
        else $error("more than one grant bit set");

endmodule

bind oc_stage_top oc_sva u_sva (.*);

//--- design/oc_stage_top.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module oc_stage_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  logic [`OC_IDX_W-1:0]   issue_oc,
    input  logic [`OC_WARP_W-1:0]  issue_warp,
    input  logic [`OC_INSTR_W-1:0] issue_instr,
    input  logic [`OC_SCB_W-1:0]   issue_scb,
    input  logic [`OC_LANES-1:0]   issue_mask,
    input  logic                   rd_valid,
    input  logic [`OC_IDX_W-1:0]   rd_oc,
    input  logic                   rd_slot,
    input  logic [`OC_DATA_W-1:0]  rd_data,
    input  logic                   ex_ready,
    output logic [`OC_NUM-1:0]     oc_free,
    output logic                   ex_valid,
    output logic [`OC_WARP_W-1:0]  ex_warp,
    output logic [`OC_INSTR_W-1:0] ex_instr,
    output logic                   ex_reg_write,
    output logic [`OC_IMM_W-1:0]   ex_imm,
    output logic                   ex_imm_valid,
    output logic [`OC_ALUOP_W-1:0] ex_alu_op,
    output logic                   ex_mem_write,
    output logic                   ex_mem_read,
    output logic                   ex_shared_gbar,
    output logic                   ex_beq,
    output logic                   ex_blt,
    output logic [`OC_SCB_W-1:0]   ex_scb,
    output logic [`OC_LANES-1:0]   ex_mask,
    output logic [`OC_REG_W-1:0]   ex_dst,
    output logic [`OC_DATA_W-1:0]  ex_src0,
    output logic [`OC_DATA_W-1:0]  ex_src1
);

    logic [`OC_NUM-1:0] req;
    logic [`OC_NUM-1:0] grt;
    logic               advance;
    oc_pkg::oc_entry_t  ex_entry;

    oc_if ocs [`OC_NUM] ();

    for (genvar i = 0; i < `OC_NUM; i++)
    begin : g_oc
        localparam logic [`OC_IDX_W-1:0] ID = i;

        operand_collector u_oc
        (
            .clk         (clk),
            .rst         (rst),
            .oc_id       (ID),
            .issue_valid (issue_valid),
            .issue_oc    (issue_oc),
            .issue_warp  (issue_warp),
            .issue_instr (issue_instr),
            .issue_scb   (issue_scb),
            .issue_mask  (issue_mask),
            .rd_valid    (rd_valid),
            .rd_oc       (rd_oc),
            .rd_slot     (rd_slot),
            .rd_data     (rd_data),
            .grant       (grt[i]),
            .free        (oc_free[i]),
            .oc          (ocs[i])
        );

        assign req[i] = ocs[i].ready;
    end

    oc_arbiter u_arb
    (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .advance (advance),
        .grt     (grt)
    );

    oc_ex_mux u_mux
    (
        .clk      (clk),
        .rst      (rst),
        .grt      (grt),
        .ocs      (ocs),
        .ex_ready (ex_ready),
        .advance  (advance),
        .ex_valid (ex_valid),
        .ex_entry (ex_entry),
        .ex_src0  (ex_src0),
        .ex_src1  (ex_src1)
    );

    assign ex_warp        = ex_entry.warp;
    assign ex_instr       = ex_entry.instr;
    assign ex_reg_write   = ex_entry.reg_write;
    assign ex_imm         = ex_entry.imm;
    assign ex_imm_valid   = ex_entry.imm_valid;
    assign ex_alu_op      = ex_entry.alu_op;
    assign ex_mem_write   = ex_entry.mem_write;
    assign ex_mem_read    = ex_entry.mem_read;
    assign ex_shared_gbar = ex_entry.shared_gbar;
    assign ex_beq         = ex_entry.beq;
    assign ex_blt         = ex_entry.blt;
    assign ex_scb         = ex_entry.scb;
    assign ex_mask        = ex_entry.mask;
    assign ex_dst         = ex_entry.dst;

endmodule

//--- design/oc_ex_mux.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module oc_ex_mux
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`OC_NUM-1:0] grt,
    oc_if.consumer             ocs [`OC_NUM],
    input  logic               ex_ready,
    output logic               advance,
    output logic               ex_valid,
    output oc_pkg::oc_entry_t  ex_entry,
    output oc_pkg::operand_t   ex_src0,
    output oc_pkg::operand_t   ex_src1
);

    oc_pkg::oc_entry_t sel_entry;
    oc_pkg::operand_t  sel_src0;
    oc_pkg::operand_t  sel_src1;

    // register empty or being drained this cycle
    assign advance = ~ex_valid | ex_ready;

    always_comb
    begin
        case (grt)
            4'b0001:
            begin
                sel_entry = ocs[0].entry;
                sel_src0  = ocs[0].src0;
                sel_src1  = ocs[0].src1;
            end
            4'b0010:
            begin
                sel_entry = ocs[1].entry;
                sel_src0  = ocs[1].src0;
                sel_src1  = ocs[1].src1;
            end
            4'b0100:
            begin
                sel_entry = ocs[2].entry;
                sel_src0  = ocs[2].src0;
                sel_src1  = ocs[2].src1;
            end
            default:   // 4'b1000, or no grant where nothing loads
            begin
                sel_entry = ocs[3].entry;
                sel_src0  = ocs[3].src0;
                sel_src1  = ocs[3].src1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ex_valid <= 1'b0;
        else if (advance)
            ex_valid <= |grt;
    end

    // held while stalled
    always_ff @(posedge clk)
    begin
        if (advance && (|grt))
        begin
            ex_entry <= sel_entry;
            ex_src0  <= sel_src0;
            ex_src1  <= sel_src1;
        end
    end

endmodule

//--- design/oc_arbiter.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module oc_arbiter
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`OC_NUM-1:0] req,
    input  logic               advance,
    output logic [`OC_NUM-1:0] grt
);

    logic [`OC_IDX_W-1:0] last_q;   // last granted collector
    logic [`OC_IDX_W-1:0] idx;
    logic [`OC_IDX_W-1:0] grt_idx;
    logic                 found;

    // search starts one past the last grant and wraps
    always_comb
    begin
        grt     = '0;
        grt_idx = last_q;
        found   = 1'b0;
        idx     = last_q;
        if (advance)
        begin
            for (int k = 1; k <= `OC_NUM; k++)
            begin
                idx = last_q + k[`OC_IDX_W-1:0];
                if (!found && req[idx])
                begin
                    found    = 1'b1;
                    grt_idx  = idx;
                    grt[idx] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            last_q <= '1;   // first search begins at collector 0
        else if (found)
            last_q <= grt_idx;
    end

endmodule

//--- design/operand_collector.sv
`timescale 1ns/1ps
`include "oc_macros.svh"

module operand_collector
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`OC_IDX_W-1:0]  oc_id,      // constant from the top's generate index
    input  logic                  issue_valid,
    input  logic [`OC_IDX_W-1:0]  issue_oc,
    input  logic [`OC_WARP_W-1:0] issue_warp,
    input  oc_pkg::instr_t        issue_instr,
    input  logic [`OC_SCB_W-1:0]  issue_scb,
    input  logic [`OC_LANES-1:0]  issue_mask,
    input  logic                  rd_valid,
    input  logic [`OC_IDX_W-1:0]  rd_oc,
    input  logic                  rd_slot,
    input  oc_pkg::operand_t      rd_data,
    input  logic                  grant,
    output logic                  free,
    oc_if.collector               oc
);

    logic                  busy;
    logic [1:0]            filled;
    logic [1:0]            need;
    logic                  issue_hit;
    logic                  rd_hit;
    oc_pkg::instr_t        instr_q;
    logic [`OC_WARP_W-1:0] warp_q;
    logic [`OC_SCB_W-1:0]  scb_q;
    logic [`OC_LANES-1:0]  mask_q;
    oc_pkg::operand_t      src0_q;
    oc_pkg::operand_t      src1_q;
    oc_pkg::instr_hi_t     hi;

    assign issue_hit = issue_valid && (issue_oc == oc_id);
    assign rd_hit    = rd_valid && (rd_oc == oc_id);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy   <= 1'b0;
            filled <= 2'b00;
            need   <= 2'b00;
        end
        else if (issue_hit)
        begin
            busy   <= 1'b1;
            filled <= 2'b00;
            // immediate format reads operand 0 only
            need   <= (issue_instr.i_fmt.hi.fmt == `OC_FMT_IMM) ? 2'b01 : 2'b11;
        end
        else if (grant)
        begin
            busy   <= 1'b0;
            filled <= 2'b00;
            need   <= 2'b00;
        end
        else if (rd_hit)
        begin
            filled[rd_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue_hit)
        begin
            instr_q <= issue_instr;
            warp_q  <= issue_warp;
            scb_q   <= issue_scb;
            mask_q  <= issue_mask;
        end
        if (rd_hit && !rd_slot)
            src0_q <= rd_data;
        if (rd_hit && rd_slot)
            src1_q <= rd_data;
    end

    assign free     = ~busy;
    assign oc.ready = busy && ((filled & need) == need);
    assign oc.src0  = src0_q;
    assign oc.src1  = need[1] ? src1_q : '0;   // no stale data on imm format

    always_comb
    begin
        oc.entry       = '0;
        oc.entry.warp  = warp_q;
        oc.entry.instr = instr_q;
        oc.entry.scb   = scb_q;
        oc.entry.mask  = mask_q;
        hi             = instr_q.r_fmt.hi;
        if (hi.fmt == `OC_FMT_IMM)
        begin
            oc.entry.imm       = instr_q.i_fmt.imm;
            oc.entry.imm_valid = 1'b1;
        end
        oc.entry.reg_write   = hi.reg_write;
        oc.entry.alu_op      = hi.alu_op;
        oc.entry.mem_write   = hi.mem_write;
        oc.entry.mem_read    = hi.mem_read;
        oc.entry.shared_gbar = hi.shared_gbar;
        oc.entry.beq         = hi.beq;
        oc.entry.blt         = hi.blt;
        oc.entry.dst         = hi.dst;
    end

endmodule

//--- design/oc_if.sv
`timescale 1ns/1ps

// one collector's view toward the arbiter and the output mux
interface oc_if;

    logic              ready;   // all needed slots filled
    oc_pkg::oc_entry_t entry;
    oc_pkg::operand_t  src0;
    oc_pkg::operand_t  src1;

    modport collector
    (
        output ready,
        output entry,
        output src0,
        output src1
    );

    modport consumer
    (
        input ready,
        input entry,
        input src0,
        input src1
    );

endinterface

//--- design/oc_pkg.sv
`include "oc_macros.svh"

package oc_pkg;

    // upper half common to both formats
    typedef struct packed {
        logic [`OC_ALUOP_W-1:0] alu_op;
        logic                   fmt;         // 1 = immediate format
        logic [`OC_REG_W-1:0]   dst;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   shared_gbar;
        logic                   beq;
        logic                   blt;
    } instr_hi_t;

    typedef struct packed {
        instr_hi_t            hi;
        logic [`OC_REG_W-1:0] src_a;
        logic [`OC_REG_W-1:0] src_b;
        logic [5:0]           rsvd;
    } r_fmt_t;

    typedef struct packed {
        instr_hi_t            hi;
        logic [`OC_IMM_W-1:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef struct packed {
        logic [`OC_WARP_W-1:0]  warp;
        instr_t                 instr;
        logic                   reg_write;
        logic [`OC_IMM_W-1:0]   imm;
        logic                   imm_valid;
        logic [`OC_ALUOP_W-1:0] alu_op;
        logic                   mem_write;
        logic                   mem_read;
        logic                   shared_gbar;
        logic                   beq;
        logic                   blt;
        logic [`OC_SCB_W-1:0]   scb;
        logic [`OC_LANES-1:0]   mask;
        logic [`OC_REG_W-1:0]   dst;
    } oc_entry_t;

    typedef logic [`OC_DATA_W-1:0] operand_t;

endpackage

//--- include/oc_macros.svh
`ifndef OC_MACROS_SVH
`define OC_MACROS_SVH

// collector count and index width fixed by the 4-bit one-hot grant
`define OC_NUM      4
`define OC_IDX_W    2

`define OC_LANES    8
`define OC_DATA_W   256   // 8 lanes x 32 bits
`define OC_WARP_W   3
`define OC_SCB_W    2

`define OC_INSTR_W  32
`define OC_ALUOP_W  4
`define OC_REG_W    5
`define OC_IMM_W    16

`define OC_FMT_REG  1'b0
`define OC_FMT_IMM  1'b1

`endif
